//--- common/tcdm_pkg.sv
package tcdm_pkg;

  // Data path width of one TCDM word
  localparam int unsigned DATA_WIDTH = 32;

  // Word address as seen by a core
  localparam int unsigned WORD_ADDR_WIDTH = 8;

  // Default bank count of the cluster
  localparam int unsigned NUM_BANKS = 4;

  // Low address bits that pick the bank (word interleaving)
  localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);

  // Remaining address bits index a word inside the bank
  localparam int unsigned BANK_IDX_WIDTH = WORD_ADDR_WIDTH - BANK_SEL_WIDTH;

  typedef logic [DATA_WIDTH-1:0]      data_t;       // One data word
  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;  // Core side word address

endpackage

//--- common/ecc_pkg.sv
package ecc_pkg;

  localparam int unsigned PARITY_WIDTH = 7;  // Hamming bits plus overall
  localparam int unsigned CODE_WIDTH   = tcdm_pkg::DATA_WIDTH + PARITY_WIDTH;  // 39 bit codeword

  typedef logic [CODE_WIDTH-1:0] codeword_t;  // Stored word with overall parity in bit 0

  typedef struct packed {
    tcdm_pkg::data_t data;    // Corrected payload
    logic            corr;    // Single bit error fixed
    logic            uncorr;  // Double bit error seen
  } secded_dec_t;

  // Wishbone register map of the ECC manager
  localparam int unsigned WB_ADDR_WIDTH = 4;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CORR_COUNT   = 4'd0;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_UNCORR_COUNT = 4'd1;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_INJECT_MASK  = 4'd2;

  function automatic codeword_t secded_encode(input tcdm_pkg::data_t data);
    codeword_t   cw;
    logic        par;
    int unsigned d;
    cw = '0;
    d  = 0;
    for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin  // Data fills non power of two slots
        cw[pos] = data[d];
        d++;
      end
    end
    for (int unsigned p = 0; p < PARITY_WIDTH - 1; p++) begin
      par = 1'b0;
      for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
        if (((pos >> p) & 1) != 0) begin
          par ^= cw[pos];  // Parity slot itself still zero here
        end
      end
      cw[1 << p] = par;
    end
    cw[0] = ^cw[CODE_WIDTH-1:1];  // Overall parity for double detection
    return cw;
  endfunction

  function automatic secded_dec_t secded_decode(input codeword_t cw);
    secded_dec_t               res;
    codeword_t                 fixed;
    logic [PARITY_WIDTH-2:0]   syn;
    int unsigned               d;
    syn = '0;
    for (int unsigned p = 0; p < PARITY_WIDTH - 1; p++) begin
      for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
        if (((pos >> p) & 1) != 0) begin
          syn[p] ^= cw[pos];
        end
      end
    end
    fixed      = cw;
    res.corr   = 1'b0;
    res.uncorr = 1'b0;
    if (^cw) begin                      // Odd flip count
      if (syn < CODE_WIDTH) begin
        fixed[syn] = ~fixed[syn];       // Syndrome zero hits overall bit
        res.corr   = 1'b1;
      end else begin
        res.uncorr = 1'b1;              // Points outside the word
      end
    end else if (syn != '0) begin
      res.uncorr = 1'b1;                // Even flips with nonzero syndrome
    end
    d = 0;
    for (int unsigned pos = 1; pos < CODE_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        res.data[d] = fixed[pos];
        d++;
      end
    end
    return res;
  endfunction

endpackage

//--- common/tcdm_bank_if.sv
interface tcdm_bank_if #(
  parameter int unsigned ADDR_WIDTH = tcdm_pkg::WORD_ADDR_WIDTH - tcdm_pkg::BANK_SEL_WIDTH,
  parameter int unsigned ID_WIDTH   = 2
) ();

  // Request side, driven by the crossbar
  logic                  req;    // Bank takes every request
  logic                  we;     // Write when high
  logic [ADDR_WIDTH-1:0] addr;   // In-bank word index
  tcdm_pkg::data_t       wdata;
  logic [ID_WIDTH-1:0]   id;     // Winning core

  // Response side, driven by the bank
  logic                  rvalid;  // One cycle after req
  tcdm_pkg::data_t       rdata;   // Zero on writes
  logic                  rerr;    // Uncorrectable read
  logic [ID_WIDTH-1:0]   rid;     // Core to route back to

  modport xbar_mp (
    output req, we, addr, wdata, id,
    input  rvalid, rdata, rerr, rid
  );

  modport bank_mp (
    input  req, we, addr, wdata, id,
    output rvalid, rdata, rerr, rid
  );

endinterface

//--- rtl/tcdm_xbar.sv
module tcdm_xbar #(
  parameter int unsigned N_CORE = 4,
  parameter int unsigned N_MEM  = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [N_CORE-1:0]                  core_req_i,
  input  logic [N_CORE-1:0]                  core_we_i,
  input  tcdm_pkg::word_addr_t [N_CORE-1:0]  core_addr_i,
  input  tcdm_pkg::data_t [N_CORE-1:0]       core_wdata_i,
  output logic [N_CORE-1:0]                  core_gnt_o,
  output logic [N_CORE-1:0]                  core_rvalid_o,
  output tcdm_pkg::data_t [N_CORE-1:0]       core_rdata_o,
  output logic [N_CORE-1:0]                  core_rerr_o,
  tcdm_bank_if.xbar_mp                       bank_o [N_MEM]
);

  localparam int unsigned SEL_W = $clog2(N_MEM);                     // Bank select bits
  localparam int unsigned IDX_W = tcdm_pkg::WORD_ADDR_WIDTH - SEL_W;  // In-bank index bits
  localparam int unsigned ID_W  = (N_CORE > 1) ? $clog2(N_CORE) : 1;

  logic [N_MEM-1:0][N_CORE-1:0] bank_req;  // Requests sorted per bank
  logic [N_MEM-1:0]             win_vld;   // Bank has a winner
  logic [N_MEM-1:0][ID_W-1:0]   win_id;    // Winner this cycle
  logic [N_MEM-1:0][ID_W-1:0]   rr_q;      // Last granted core per bank
  logic [N_MEM-1:0]             rsp_vld;
  logic [N_MEM-1:0]             rsp_err;
  logic [N_MEM-1:0][ID_W-1:0]   rsp_id;
  tcdm_pkg::data_t [N_MEM-1:0]  rsp_data;

  // Low address bits pick the bank
  always_comb begin : bank_decode
    bank_req = '0;
    for (int c = 0; c < N_CORE; c++) begin
      bank_req[core_addr_i[c][SEL_W-1:0]][c] = core_req_i[c];
    end
  end

  // Round robin starting after the last winner
  always_comb begin : rr_arbiter
    int unsigned cand;
    win_vld = '0;
    win_id  = '0;
    for (int m = 0; m < N_MEM; m++) begin
      for (int k = N_CORE; k >= 1; k--) begin  // Nearest candidate assigned last
        cand = (rr_q[m] + k) % N_CORE;
        if (bank_req[m][cand]) begin
          win_vld[m] = 1'b1;
          win_id[m]  = ID_W'(cand);
        end
      end
    end
  end

  always_comb begin : grant_map
    core_gnt_o = '0;
    for (int m = 0; m < N_MEM; m++) begin
      if (win_vld[m]) begin
        core_gnt_o[win_id[m]] = 1'b1;  // Core targets one bank only
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_pointer
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int m = 0; m < N_MEM; m++) begin
        if (win_vld[m]) begin
          rr_q[m] <= win_id[m];  // Move only on a grant
        end
      end
    end
  end

  for (genvar m = 0; m < N_MEM; m++) begin : gen_bank_port
    assign bank_o[m].req   = win_vld[m];
    assign bank_o[m].we    = core_we_i[win_id[m]];
    assign bank_o[m].addr  = core_addr_i[win_id[m]][SEL_W +: IDX_W];  // Drop bank bits
    assign bank_o[m].wdata = core_wdata_i[win_id[m]];
    assign bank_o[m].id    = win_id[m];
    assign rsp_vld[m]      = bank_o[m].rvalid;
    assign rsp_err[m]      = bank_o[m].rerr;
    assign rsp_id[m]       = bank_o[m].rid;
    assign rsp_data[m]     = bank_o[m].rdata;
  end

  // Returned id alone names the core
  always_comb begin : rsp_route
    core_rvalid_o = '0;
    core_rdata_o  = '0;
    core_rerr_o   = '0;
    for (int m = 0; m < N_MEM; m++) begin
      if (rsp_vld[m]) begin
        core_rvalid_o[rsp_id[m]] = 1'b1;
        core_rdata_o[rsp_id[m]]  = rsp_data[m];
        core_rerr_o[rsp_id[m]]   = rsp_err[m];
      end
    end
  end

endmodule

//--- ecc/tcdm_ecc_bank.sv
module tcdm_ecc_bank #(
  parameter int unsigned N_CORE     = 4,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  tcdm_bank_if.bank_mp       port_i,
  input  ecc_pkg::codeword_t inject_mask_i,
  output logic               bank_write_o,
  output logic               corr_err_o,
  output logic               uncorr_err_o
);

  localparam int unsigned ID_W = (N_CORE > 1) ? $clog2(N_CORE) : 1;

  ecc_pkg::codeword_t   mem_q [BANK_DEPTH];  // Codeword array
  ecc_pkg::codeword_t   code_q;              // Word read at request time
  ecc_pkg::secded_dec_t dec;                 // Decoder result
  logic                 rvalid_q;            // Response cycle marker
  logic                 read_q;              // Response belongs to a read
  logic [ID_W-1:0]      rid_q;               // Initiator to answer
  logic                 wr_en;

  assign wr_en        = port_i.req & port_i.we;
  assign bank_write_o = wr_en;  // Lets the manager drop its mask

  // Encode on the way in and flip bits by the pending mask
  always_ff @(posedge clk_i) begin : storage
    if (wr_en) begin
      mem_q[port_i.addr] <= ecc_pkg::secded_encode(port_i.wdata) ^ inject_mask_i;
    end
    if (port_i.req) begin
      code_q <= mem_q[port_i.addr];  // Synchronous read
      rid_q  <= port_i.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rsp_ctrl
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      read_q   <= 1'b0;
    end else begin
      rvalid_q <= port_i.req;                // Every request is answered
      read_q   <= port_i.req & ~port_i.we;
    end
  end

  // Decode in the response cycle
  assign dec = ecc_pkg::secded_decode(code_q);

  assign port_i.rvalid = rvalid_q;
  assign port_i.rid    = rid_q;
  assign port_i.rdata  = read_q ? dec.data : '0;  // Writes return zero
  assign port_i.rerr   = read_q & dec.uncorr;

  // Error events only on valid reads
  assign corr_err_o   = read_q & dec.corr;
  assign uncorr_err_o = read_q & dec.uncorr;

endmodule

//--- ecc/ecc_manager.sv
module ecc_manager #(
  parameter int unsigned N_MEM = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [ecc_pkg::WB_ADDR_WIDTH-1:0] wb_adr_i,
  input  tcdm_pkg::data_t                   wb_dat_i,
  output tcdm_pkg::data_t                   wb_dat_o,
  output logic                              wb_ack_o,
  input  logic [N_MEM-1:0]                  bank_write_i,
  input  logic [N_MEM-1:0]                  corr_err_i,
  input  logic [N_MEM-1:0]                  uncorr_err_i,
  output ecc_pkg::codeword_t                inject_mask_o
);

  localparam int unsigned CNT_W = $clog2(N_MEM + 1);  // Holds a full bank count

  logic            ack_q;         // Single cycle ack
  logic            access;        // New Wishbone access
  logic            wr_access;
  tcdm_pkg::data_t corr_cnt_q;
  tcdm_pkg::data_t uncorr_cnt_q;
  tcdm_pkg::data_t mask_q;        // Low 32 codeword bits
  logic [CNT_W-1:0] corr_hits;    // Banks flagging this cycle
  logic [CNT_W-1:0] uncorr_hits;

  function automatic tcdm_pkg::data_t sat_add(input tcdm_pkg::data_t cnt,
                                              input logic [CNT_W-1:0] hits);
    logic [tcdm_pkg::DATA_WIDTH:0] sum;
    sum = {1'b0, cnt} + hits;
    return sum[tcdm_pkg::DATA_WIDTH] ? '1 : sum[tcdm_pkg::DATA_WIDTH-1:0];  // Stick at max
  endfunction

  // Ack low blocks a second access while acking
  assign access    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_access = access & wb_we_i;

  always_comb begin : hit_count
    corr_hits   = '0;
    uncorr_hits = '0;
    for (int i = 0; i < N_MEM; i++) begin
      corr_hits   = corr_hits + CNT_W'(corr_err_i[i]);
      uncorr_hits = uncorr_hits + CNT_W'(uncorr_err_i[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
      mask_q       <= '0;
    end else begin
      ack_q        <= access;
      corr_cnt_q   <= sat_add(corr_cnt_q, corr_hits);
      uncorr_cnt_q <= sat_add(uncorr_cnt_q, uncorr_hits);
      if (wr_access && wb_adr_i == ecc_pkg::REG_CORR_COUNT) begin
        corr_cnt_q <= '0;    // Clear wins over new events
      end
      if (wr_access && wb_adr_i == ecc_pkg::REG_UNCORR_COUNT) begin
        uncorr_cnt_q <= '0;
      end
      if (|bank_write_i) begin
        mask_q <= '0;        // One shot mask used up by this write
      end
      if (wr_access && wb_adr_i == ecc_pkg::REG_INJECT_MASK) begin
        mask_q <= wb_dat_i;  // Fresh load survives a same cycle write
      end
    end
  end

  assign wb_ack_o = ack_q;

  // Read data follows the held address
  always_comb begin : read_mux
    case (wb_adr_i)
      ecc_pkg::REG_CORR_COUNT:   wb_dat_o = corr_cnt_q;
      ecc_pkg::REG_UNCORR_COUNT: wb_dat_o = uncorr_cnt_q;
      ecc_pkg::REG_INJECT_MASK:  wb_dat_o = mask_q;
      default:                   wb_dat_o = '0;  // Unused addresses
    endcase
  end

  assign inject_mask_o = ecc_pkg::codeword_t'(mask_q);  // Parity top bits never flipped

endmodule

//--- rtl/ecc_tcdm_top.sv
module ecc_tcdm_top #(
  parameter int unsigned N_CORE     = 4,
  parameter int unsigned N_MEM      = tcdm_pkg::NUM_BANKS,  // Power of two
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [N_CORE-1:0]                 core_req_i,
  input  logic [N_CORE-1:0]                 core_we_i,
  input  tcdm_pkg::word_addr_t [N_CORE-1:0] core_addr_i,
  input  tcdm_pkg::data_t [N_CORE-1:0]      core_wdata_i,
  output logic [N_CORE-1:0]                 core_gnt_o,
  output logic [N_CORE-1:0]                 core_rvalid_o,
  output tcdm_pkg::data_t [N_CORE-1:0]      core_rdata_o,
  output logic [N_CORE-1:0]                 core_rerr_o,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [ecc_pkg::WB_ADDR_WIDTH-1:0] wb_adr_i,
  input  tcdm_pkg::data_t                   wb_dat_i,
  output tcdm_pkg::data_t                   wb_dat_o,
  output logic                              wb_ack_o
);

  localparam int unsigned IDX_W = tcdm_pkg::WORD_ADDR_WIDTH - $clog2(N_MEM);
  localparam int unsigned ID_W  = (N_CORE > 1) ? $clog2(N_CORE) : 1;

  logic [N_MEM-1:0]   bank_write;   // Write strobes to the manager
  logic [N_MEM-1:0]   corr_err;     // Per bank corrected read
  logic [N_MEM-1:0]   uncorr_err;   // Per bank failed read
  ecc_pkg::codeword_t inject_mask;  // Broadcast to every bank

  tcdm_bank_if #(
    .ADDR_WIDTH ( IDX_W ),
    .ID_WIDTH   ( ID_W  )
  ) bank_if [N_MEM] ();

  tcdm_xbar #(
    .N_CORE ( N_CORE ),
    .N_MEM  ( N_MEM  )
  ) u_xbar (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .core_req_i    ( core_req_i    ),
    .core_we_i     ( core_we_i     ),
    .core_addr_i   ( core_addr_i   ),
    .core_wdata_i  ( core_wdata_i  ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_rerr_o   ( core_rerr_o   ),
    .bank_o        ( bank_if       )
  );

  for (genvar m = 0; m < N_MEM; m++) begin : gen_bank
    tcdm_ecc_bank #(
      .N_CORE     ( N_CORE     ),
      .BANK_DEPTH ( BANK_DEPTH )
    ) u_bank (
      .clk_i         ( clk_i         ),
      .rst_ni        ( rst_ni        ),
      .port_i        ( bank_if[m]    ),
      .inject_mask_i ( inject_mask   ),
      .bank_write_o  ( bank_write[m] ),
      .corr_err_o    ( corr_err[m]   ),
      .uncorr_err_o  ( uncorr_err[m] )
    );
  end

  ecc_manager #(
    .N_MEM ( N_MEM )
  ) u_ecc_manager (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .wb_cyc_i      ( wb_cyc_i    ),
    .wb_stb_i      ( wb_stb_i    ),
    .wb_we_i       ( wb_we_i     ),
    .wb_adr_i      ( wb_adr_i    ),
    .wb_dat_i      ( wb_dat_i    ),
    .wb_dat_o      ( wb_dat_o    ),
    .wb_ack_o      ( wb_ack_o    ),
    .bank_write_i  ( bank_write  ),
    .corr_err_i    ( corr_err    ),
    .uncorr_err_i  ( uncorr_err  ),
    .inject_mask_o ( inject_mask )
  );

endmodule

//--- dv/ecc_tcdm_properties.sv
module ecc_tcdm_properties #(
  parameter int unsigned N_CORE = 4,
  parameter int unsigned N_MEM  = 4
) (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic [N_CORE-1:0]                 core_req_i,
  input tcdm_pkg::word_addr_t [N_CORE-1:0] core_addr_i,
  input logic [N_CORE-1:0]                 core_gnt_o,
  input logic [N_CORE-1:0]                 core_rvalid_o,
  input logic [N_CORE-1:0]                 core_rerr_o,
  input logic                              wb_cyc_i,
  input logic                              wb_stb_i,
  input logic                              wb_ack_o
);

  localparam int unsigned SEL_W = $clog2(N_MEM);  // Bank select bits

  int unsigned fail_cnt = 0;  // Failed assertions so far

  for (genvar c = 0; c < N_CORE; c++) begin : gen_core
    int unsigned wait_q;  // Cycles spent waiting for a grant

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wait_q <= 0;
      end else begin
        wait_q <= (core_req_i[c] && !core_gnt_o[c]) ? wait_q + 1 : 0;
      end
    end

    a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_gnt_o[c] |-> core_req_i[c])
      else begin
        fail_cnt++;
        $error("Grant without request on core %0d", c);
      end
    a_rsp_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (core_req_i[c] && core_gnt_o[c]) |=> core_rvalid_o[c])
      else begin
        fail_cnt++;
        $error("Missing response on core %0d", c);
      end
    a_rsp_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rvalid_o[c] |-> $past(core_req_i[c] && core_gnt_o[c]))
      else begin
        fail_cnt++;
        $error("Response without accepted request on core %0d", c);
      end
    a_rerr_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rerr_o[c] |-> core_rvalid_o[c])
      else begin
        fail_cnt++;
        $error("Error flag outside a response on core %0d", c);
      end
    a_fair: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (core_req_i[c] && !core_gnt_o[c]) |-> wait_q < N_CORE - 1)
      else begin
        fail_cnt++;
        $error("Core %0d starved past %0d cycles", c, N_CORE);
      end

    for (genvar d = c + 1; d < N_CORE; d++) begin : gen_pair
      a_one_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
          !(core_gnt_o[c] && core_gnt_o[d] &&
            core_addr_i[c][SEL_W-1:0] == core_addr_i[d][SEL_W-1:0]))
        else begin
          fail_cnt++;
          $error("Cores %0d and %0d granted one bank", c, d);
        end
    end
  end

  a_wb_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(wb_cyc_i && wb_stb_i) |=> wb_ack_o)
    else begin
      fail_cnt++;
      $error("Wishbone ack late");
    end
  a_wb_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_o |=> !wb_ack_o)
    else begin
      fail_cnt++;
      $error("Wishbone ack longer than one cycle");
    end
  a_wb_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      fail_cnt++;
      $error("Wishbone ack without a cycle");
    end

endmodule

//--- dv/tb_ecc_tcdm.sv
module tb_ecc_tcdm;

  localparam int unsigned N_CORE       = 4;
  localparam int unsigned N_MEM        = 4;
  localparam int unsigned BANK_DEPTH   = 64;
  localparam int unsigned ADDR_SPAN    = 2 ** tcdm_pkg::WORD_ADDR_WIDTH;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned INIT_OPS     = ADDR_SPAN / N_CORE;  // Each core fills its own bank
  localparam int unsigned RAND_OPS     = 120;
  localparam int unsigned DIRECT_CYC   = 100;                 // Wishbone and ECC tests
  localparam int unsigned STIM_CYCLES  = RESET_CYCLES + INIT_OPS + RAND_OPS * N_CORE + DIRECT_CYC;
  localparam int unsigned CYCLE_LIMIT  = 4 * STIM_CYCLES;

  logic                              clk_i;
  logic                              rst_ni;
  logic [N_CORE-1:0]                 core_req_i;
  logic [N_CORE-1:0]                 core_we_i;
  tcdm_pkg::word_addr_t [N_CORE-1:0] core_addr_i;
  tcdm_pkg::data_t [N_CORE-1:0]      core_wdata_i;
  logic [N_CORE-1:0]                 core_gnt_o;
  logic [N_CORE-1:0]                 core_rvalid_o;
  tcdm_pkg::data_t [N_CORE-1:0]      core_rdata_o;
  logic [N_CORE-1:0]                 core_rerr_o;
  logic                              wb_cyc_i;
  logic                              wb_stb_i;
  logic                              wb_we_i;
  logic [ecc_pkg::WB_ADDR_WIDTH-1:0] wb_adr_i;
  tcdm_pkg::data_t                   wb_dat_i;
  tcdm_pkg::data_t                   wb_dat_o;
  logic                              wb_ack_o;

  tcdm_pkg::data_t ref_mem   [ADDR_SPAN];                   // Last written word
  int unsigned     ref_flips [ADDR_SPAN] = '{default: 0};   // Codeword bits flipped on store
  logic [N_CORE-1:0] exp_vld;                               // Response due this cycle
  tcdm_pkg::data_t exp_data  [N_CORE];
  int unsigned     exp_flips [N_CORE];
  tcdm_pkg::data_t mask_model;                              // Pending injection mask
  logic            wb_chk = 1'b0;                           // Compare next Wishbone read
  tcdm_pkg::data_t wb_exp = '0;
  int unsigned     err_cnt = 0;
  int unsigned     cycle_cnt = 0;
  logic [31:0]     rng [N_CORE];                            // One stream per core

  ecc_tcdm_top #(
    .N_CORE     ( N_CORE     ),
    .N_MEM      ( N_MEM      ),
    .BANK_DEPTH ( BANK_DEPTH )
  ) UUT (.*);

  bind ecc_tcdm_top ecc_tcdm_properties #(
    .N_CORE ( N_CORE ),
    .N_MEM  ( N_MEM  )
  ) u_props (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .core_req_i    ( core_req_i    ),
    .core_addr_i   ( core_addr_i   ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rerr_o   ( core_rerr_o   ),
    .wb_cyc_i      ( wb_cyc_i      ),
    .wb_stb_i      ( wb_stb_i      ),
    .wb_ack_o      ( wb_ack_o      )
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;  // Period 20

  // Word memory and flip count per address
  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    if (!rst_ni) begin
      exp_vld    <= '0;
      mask_model <= '0;
    end else begin
      exp_vld <= core_req_i & core_gnt_o;
      for (int c = 0; c < N_CORE; c++) begin
        if (core_req_i[c] && core_gnt_o[c]) begin
          exp_data[c]  <= core_we_i[c] ? '0 : ref_mem[core_addr_i[c]];
          exp_flips[c] <= core_we_i[c] ? 0 : ref_flips[core_addr_i[c]];
          if (core_we_i[c]) begin
            ref_mem[core_addr_i[c]]   <= core_wdata_i[c];
            ref_flips[core_addr_i[c]] <= $countones(mask_model);
          end
        end
      end
      if (|(core_req_i & core_gnt_o & core_we_i)) begin
        mask_model <= '0;  // Used up by the write
      end
      if (wb_ack_o && wb_we_i && wb_adr_i == ecc_pkg::REG_INJECT_MASK) begin
        mask_model <= wb_dat_i;
      end
    end
  end

  for (genvar c = 0; c < N_CORE; c++) begin : gen_check
    a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (exp_vld[c] && exp_flips[c] < 2) |-> core_rdata_o[c] == exp_data[c])
      else begin
        err_cnt++;
        $display("ERROR: core_rdata_o[%0d] = %h, expected %h", c,
                 $sampled(core_rdata_o[c]), $sampled(exp_data[c]));
      end
    a_rerr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_vld[c] |-> core_rerr_o[c] == (exp_flips[c] >= 2))
      else begin
        err_cnt++;
        $display("ERROR: core_rerr_o[%0d] = %h, expected %h", c,
                 $sampled(core_rerr_o[c]), $sampled(exp_flips[c]) >= 2);
      end
  end

  a_wb_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (wb_ack_o && wb_chk) |-> wb_dat_o == wb_exp)
    else begin
      err_cnt++;
      $display("ERROR: wb_dat_o = %h, expected %h", $sampled(wb_dat_o), $sampled(wb_exp));
    end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Request held until granted and grant sampled mid cycle
  task automatic core_access(input int c, input logic we, input tcdm_pkg::word_addr_t addr,
                             input tcdm_pkg::data_t data);
    logic granted;
    core_req_i[c]   = 1'b1;
    core_we_i[c]    = we;
    core_addr_i[c]  = addr;
    core_wdata_i[c] = data;
    do begin
      @(negedge clk_i);
      granted = core_gnt_o[c];
      @(posedge clk_i);
      #2;
    end while (!granted);
    core_req_i[c] = 1'b0;
  endtask

  task automatic wb_access(input logic we, input logic [ecc_pkg::WB_ADDR_WIDTH-1:0] adr,
                           input tcdm_pkg::data_t dat);
    logic acked;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(negedge clk_i);
      acked = wb_ack_o;
      @(posedge clk_i);
      #2;
    end while (!acked);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;  // Idle cycle before the next access
    @(posedge clk_i);
    #2;
  endtask

  task automatic wb_read(input logic [ecc_pkg::WB_ADDR_WIDTH-1:0] adr,
                         input tcdm_pkg::data_t expected);
    wb_exp = expected;
    wb_chk = 1'b1;
    wb_access(1'b0, adr, '0);
    wb_chk = 1'b0;
  endtask

  task automatic fill_bank(input int c);
    for (int i = 0; i < INIT_OPS; i++) begin
      rng[c] = xorshift(rng[c]);
      core_access(c, 1'b1, tcdm_pkg::word_addr_t'(N_CORE * i + c), rng[c]);  // Bank c only
    end
  endtask

  task automatic random_traffic(input int c);
    tcdm_pkg::word_addr_t addr;
    logic                 we;
    for (int i = 0; i < RAND_OPS; i++) begin
      rng[c] = xorshift(rng[c]);
      addr   = rng[c][tcdm_pkg::WORD_ADDR_WIDTH-1:0];
      we     = rng[c][31];
      rng[c] = xorshift(rng[c]);
      core_access(c, we, addr, rng[c]);
    end
  endtask

  initial begin : stimulus
    logic [31:0]          seed;
    tcdm_pkg::word_addr_t addr;
    tcdm_pkg::data_t      data;
    tcdm_pkg::data_t      mask;
    rst_ni       = 1'b0;
    core_req_i   = '0;
    core_we_i    = '0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    seed         = 32'ha3b83eb5;
    for (int c = 0; c < N_CORE; c++) begin
      seed   = xorshift(seed);
      rng[c] = seed;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);  // Quiet outputs before any request
    #2;
    for (int c = 0; c < N_CORE; c++) begin
      fork
        automatic int cc = c;
        fill_bank(cc);
      join_none
    end
    wait fork;
    for (int c = 0; c < N_CORE; c++) begin
      fork
        automatic int cc = c;
        random_traffic(cc);
      join_none
    end
    wait fork;
    seed = xorshift(seed);  // Single bit flip gets corrected
    addr = seed[tcdm_pkg::WORD_ADDR_WIDTH-1:0];
    data = xorshift(seed);
    wb_access(1'b1, ecc_pkg::REG_INJECT_MASK, 32'h1 << seed[12:8]);
    core_access(1, 1'b1, addr, data);
    core_access(1, 1'b0, addr, '0);
    wb_read(ecc_pkg::REG_CORR_COUNT, 32'd1);
    core_access(1, 1'b1, addr, ~data);
    core_access(1, 1'b0, addr, '0);
    wb_read(ecc_pkg::REG_CORR_COUNT, 32'd1);
    wb_read(ecc_pkg::REG_INJECT_MASK, '0);
    seed = xorshift(seed);  // Two adjacent flips
    mask = (32'h1 << seed[4:0]) | (32'h1 << 5'(seed[4:0] + 5'd1));
    wb_access(1'b1, ecc_pkg::REG_INJECT_MASK, mask);
    wb_read(ecc_pkg::REG_INJECT_MASK, mask);
    core_access(2, 1'b1, addr, data);
    core_access(2, 1'b0, addr, '0);
    wb_read(ecc_pkg::REG_UNCORR_COUNT, 32'd1);
    wb_access(1'b1, ecc_pkg::REG_UNCORR_COUNT, '0);
    wb_read(ecc_pkg::REG_UNCORR_COUNT, '0);
    wb_read(4'h3, '0);
    wb_read(4'hf, '0);
    repeat (3) @(posedge clk_i);
    $display("Summary: %0d value errors, %0d property errors", err_cnt, UUT.u_props.fail_cnt);
    if (err_cnt == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- build.f
common/tcdm_pkg.sv
common/ecc_pkg.sv
common/tcdm_bank_if.sv
rtl/tcdm_xbar.sv
ecc/tcdm_ecc_bank.sv
ecc/ecc_manager.sv
rtl/ecc_tcdm_top.sv
dv/ecc_tcdm_properties.sv
dv/tb_ecc_tcdm.sv

//--- Bender.yml
package:
  name: ecc_tcdm

sources:
  - common/tcdm_pkg.sv
  - common/ecc_pkg.sv
  - common/tcdm_bank_if.sv
  - rtl/tcdm_xbar.sv
  - ecc/tcdm_ecc_bank.sv
  - ecc/ecc_manager.sv
  - rtl/ecc_tcdm_top.sv
  - target: simulation
    files:
      - dv/ecc_tcdm_properties.sv
      - dv/tb_ecc_tcdm.sv
